// File: eth_tx_pkg.sv
/*
 * eth tx shared definitions
 * buffer geometry, qword types, descriptor and mac-bound bundle
 */
`default_nettype none

package eth_tx_pkg;

    //////////////////////////////
    // geometry
    //////////////////////////////
    localparam int BW             = 9;    // buffer address width
    localparam int BUF_QW         = 512;  // buffer depth in qwords
    localparam int QW_LEN_W       = 13;   // frame length field
    localparam int DESC_DEPTH_LOG = 4;    // 16 queued descriptors
    localparam int CUT_THRU_QW    = 4;    // qwords needed before a start

    //////////////////////////////
    // types
    //////////////////////////////
    typedef logic [63:0] qw_t;    // one data qword
    typedef logic [7:0]  ben_t;   // byte valid per qword lane

    // extra msb is the wrap bit, full vs empty
    typedef logic [BW:0] ptr_t;

    // frame announcement from the host
    typedef struct packed {
        logic [QW_LEN_W-1:0] qw_len;   // qwords in frame, >= 8
        ben_t                lst_ben;  // valid bytes of last qword
    } frm_desc_t;

    // everything going to the mac
    typedef struct packed {
        qw_t  data;
        ben_t data_valid;  // all ones mid-frame, partial at the end
        logic start;       // one-cycle pulse per attempt
        logic underrun;    // abort of the current attempt
    } mac_tx_t;

endpackage

`default_nettype wire

// File: eth_tx_ibuf.sv
/*
 * eth tx qword buffer
 * simple dual-port ram, one write port, registered read port
 */
`timescale 1ns/1ps
`default_nettype none

module eth_tx_ibuf import eth_tx_pkg::*; (
    input  wire logic          clk,
    // host side
    input  wire logic          wr_en_i,
    input  wire logic [BW-1:0] wr_addr_i,
    input  wire qw_t           wr_data_i,
    // sender side
    input  wire logic [BW-1:0] rd_addr_i,
    output qw_t                rd_data_o
);

    qw_t mem [BUF_QW];  // frame qwords, indexed by pointer lsbs

    //////////////////////////////
    // write port
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    //////////////////////////////
    // read port
    //////////////////////////////
    // data for rd_addr_i shows up the next cycle
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

    a_wr_addr_known: assert property (@(posedge clk)
        wr_en_i |-> !$isunknown(wr_addr_i));

    // once the sender has a read address it must never lose it
    a_rd_addr_stays_known: assert property (@(posedge clk)
        !$isunknown(rd_addr_i) |=> !$isunknown(rd_addr_i));

endmodule

`default_nettype wire

// File: eth_tx_ingress.sv
/*
 * eth tx host write side
 * producer pointer, free space against committed consumer,
 * descriptor hand-off to frame sync
 */
`timescale 1ns/1ps
`default_nettype none

module eth_tx_ingress import eth_tx_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rst,
    // host
    input  wire logic          frm_start_i,
    input  wire frm_desc_t     desc_i,
    input  wire logic          qw_wr_i,
    input  wire qw_t           qw_data_i,
    // sender, space freed at frame end
    input  wire ptr_t          committed_cons_i,
    // frame sync fifo level
    input  wire logic          desc_full_i,
    output logic               full_o,
    output logic               desc_full_o,
    // to frame sync
    output logic               desc_push_o,
    output frm_desc_t          desc_o,
    // to buffer
    output logic               wr_en_o,
    output logic [BW-1:0]      wr_addr_o,
    output qw_t                wr_data_o,
    output ptr_t               prod_ptr_o
);

    ptr_t prod_ptr;   // next slot to fill
    ptr_t used;       // qwords not yet committed by the sender
    logic wr_acc;     // write that actually lands

    //////////////////////////////
    // space accounting
    //////////////////////////////
    assign used   = prod_ptr - committed_cons_i;  // wrap bit keeps it exact
    assign full_o = (used >= ptr_t'(BUF_QW - 1)); // free space <= 1
    assign wr_acc = qw_wr_i && !full_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            prod_ptr <= '0;
        end else if (wr_acc) begin
            prod_ptr <= prod_ptr + 1'b1;
        end
    end

    // buffer write, same cycle as the host strobe
    assign wr_en_o    = wr_acc;
    assign wr_addr_o  = prod_ptr[BW-1:0];
    assign wr_data_o  = qw_data_i;
    assign prod_ptr_o = prod_ptr;   // counts the qword from the next cycle on

    //////////////////////////////
    // descriptors
    //////////////////////////////
    assign desc_push_o = frm_start_i;
    assign desc_o      = desc_i;
    assign desc_full_o = desc_full_i;   // host sees fifo level directly

    a_no_wr_when_full: assert property (@(posedge clk) disable iff (rst)
        qw_wr_i |-> !full_o);

    a_no_desc_when_full: assert property (@(posedge clk) disable iff (rst)
        frm_start_i |-> !desc_full_o);

    // committed consumer must never run past the producer
    a_cons_behind_prod: assert property (@(posedge clk) disable iff (rst)
        used <= ptr_t'(BUF_QW - 1));

endmodule

`default_nettype wire

// File: eth_tx_frm_sync.sv
/*
 * eth tx frame sync
 * descriptor fifo, qwords available, cut-through start trigger
 * and back-to-back hint for the sender
 */
`timescale 1ns/1ps
`default_nettype none

module eth_tx_frm_sync import eth_tx_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rst,
    // from ingress
    input  wire logic          desc_push_i,
    input  wire frm_desc_t     desc_i,
    input  wire ptr_t          prod_ptr_i,
    // from sender
    input  wire logic [BW-1:0] rd_addr_i,
    input  wire logic          sync_i,
    input  wire logic          rsk_tk_i,
    input  wire logic          eof_i,
    // status
    output logic               desc_full_o,
    output logic               trig_o,
    output ptr_t               diff_o,
    output frm_desc_t          head_desc_o,
    output logic               rsk_o
);

    frm_desc_t                 fifo_mem [2**DESC_DEPTH_LOG];
    logic [DESC_DEPTH_LOG-1:0] wr_ptr;
    logic [DESC_DEPTH_LOG-1:0] rd_ptr;
    logic [DESC_DEPTH_LOG:0]   count;      // 0 .. 16
    logic                      pop;
    logic                      fifo_empty;
    logic [QW_LEN_W-1:0]       thr;        // qwords needed for this head

    //////////////////////////////
    // descriptor fifo
    //////////////////////////////
    assign pop = sync_i && eof_i;  // frame done, underrun sync keeps head

    always_ff @(posedge clk) begin
        if (desc_push_i) begin
            fifo_mem[wr_ptr] <= desc_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (desc_push_i) wr_ptr <= wr_ptr + 1'b1;
            if (pop)         rd_ptr <= rd_ptr + 1'b1;
            case ({desc_push_i, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // both or neither, level unchanged
            endcase
        end
    end

    assign fifo_empty  = (count == '0);
    assign desc_full_o = count[DESC_DEPTH_LOG];  // msb only set at 16
    assign head_desc_o = fifo_mem[rd_ptr];
    assign rsk_o       = |count[DESC_DEPTH_LOG:1];  // two or more queued

    //////////////////////////////
    // availability and trigger
    //////////////////////////////
    // mod BUF_QW, never ambiguous since fill stays below depth
    assign diff_o = {1'b0, prod_ptr_i[BW-1:0] - rd_addr_i};

    assign thr = (head_desc_o.qw_len < QW_LEN_W'(CUT_THRU_QW)) ?
                 head_desc_o.qw_len : QW_LEN_W'(CUT_THRU_QW);

    // head is stale while a sync is in flight
    assign trig_o = !fifo_empty && (QW_LEN_W'(diff_o) >= thr) &&
                    !sync_i && !rsk_tk_i;

    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        desc_push_i |-> !desc_full_o);

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> !fifo_empty);

    // back-to-back only with the next descriptor already queued
    a_tk_has_next: assert property (@(posedge clk) disable iff (rst)
        rsk_tk_i |-> rsk_o);

endmodule

`default_nettype wire

// File: eth_tx_sender.sv
/*
 * eth tx sender
 * reads the qword buffer, drives the mac, rewinds on underrun
 * and commits buffer space once a frame is fully sent
 */
`timescale 1ns/1ps
`default_nettype none

module eth_tx_sender import eth_tx_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rst,
    // frame sync
    input  wire logic          trig_i,
    input  wire ptr_t          diff_i,
    input  wire frm_desc_t     head_desc_i,
    input  wire logic          rsk_i,
    output logic               rsk_tk_o,
    output logic               sync_o,
    output logic               eof_o,
    // buffer
    output logic [BW-1:0]      rd_addr_o,
    input  wire qw_t           rd_data_i,
    // mac
    input  wire logic          tx_ack_i,
    output mac_tx_t            mac_o,
    // ingress
    output ptr_t               committed_cons_o
);

    typedef enum logic [7:0] {
        S_INIT     = 8'b0000_0001,
        S_IDLE     = 8'b0000_0010,
        S_START    = 8'b0000_0100,  // start pulse
        S_PRIME    = 8'b0000_1000,  // qword 0 to mac
        S_HOLD1    = 8'b0001_0000,  // qword 0 shown, qword 1 in rd_data
        S_WAIT_ACK = 8'b0010_0000,  // qword 1 parked in aux_data
        S_STREAM   = 8'b0100_0000,
        S_REWIND   = 8'b1000_0000
    } snd_state_t;

    snd_state_t          state;
    ptr_t                rd_addr;    // keeps wrap bit for the commit
    ptr_t                sof_addr;   // qword 0 of the current attempt
    qw_t                 aux_data;
    logic [QW_LEN_W-1:0] qw_snt;     // qwords loaded into mac data so far
    logic [QW_LEN_W-1:0] len_m1;
    logic [QW_LEN_W-1:0] len_m2;
    logic                last_qw;
    qw_t                 tx_data;
    ben_t                tx_dv;
    logic                tx_start;
    logic                tx_underrun;

    assign rd_addr_o = rd_addr[BW-1:0];
    assign len_m1    = head_desc_i.qw_len - QW_LEN_W'(1);
    assign len_m2    = head_desc_i.qw_len - QW_LEN_W'(2);
    assign last_qw   = (qw_snt == len_m1);
    assign mac_o     = '{data: tx_data, data_valid: tx_dv,
                         start: tx_start, underrun: tx_underrun};

    //////////////////////////////
    // control fsm
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= S_INIT;
            rd_addr          <= '0;
            committed_cons_o <= '0;
            tx_dv            <= '0;
            tx_start         <= 1'b0;
            tx_underrun      <= 1'b0;
            sync_o           <= 1'b0;
            eof_o            <= 1'b0;
            rsk_tk_o         <= 1'b0;
        end else begin
            tx_start    <= 1'b0;   // pulses
            tx_underrun <= 1'b0;
            tx_dv       <= '0;
            sync_o      <= 1'b0;
            eof_o       <= 1'b0;
            rsk_tk_o    <= 1'b0;

            // rd_addr still sits on the next frame here
            if (eof_o) committed_cons_o <= rd_addr;

            case (state)
                S_INIT: state <= S_IDLE;
                S_IDLE: if (trig_i) state <= S_START;
                S_START: begin
                    tx_start <= 1'b1;
                    rd_addr  <= rd_addr + 1'b1;
                    state    <= S_PRIME;
                end
                S_PRIME: begin
                    tx_dv   <= '1;
                    rd_addr <= rd_addr + 1'b1;  // now on qword 2
                    state   <= S_HOLD1;
                end
                S_HOLD1, S_WAIT_ACK: begin
                    tx_dv <= '1;
                    if (tx_ack_i) begin
                        rd_addr <= rd_addr + 1'b1;
                        state   <= S_STREAM;
                    end else begin
                        state   <= S_WAIT_ACK;
                    end
                end
                S_STREAM: begin
                    if (last_qw) begin
                        tx_dv  <= head_desc_i.lst_ben;
                        sync_o <= 1'b1;
                        eof_o  <= 1'b1;
                        // rd_addr stays on the next frame's qword 0
                        if (rsk_i && diff_i >= ptr_t'(CUT_THRU_QW)) begin
                            rsk_tk_o <= 1'b1;
                            state    <= S_START;
                        end else begin
                            state    <= S_IDLE;
                        end
                    end else if (diff_i == ptr_t'(1) && qw_snt != len_m2) begin
                        tx_underrun <= 1'b1;   // host fell behind
                        rd_addr     <= sof_addr;
                        state       <= S_REWIND;
                    end else begin
                        tx_dv   <= '1;
                        rd_addr <= rd_addr + 1'b1;
                    end
                end
                S_REWIND: begin
                    sync_o <= 1'b1;  // no pop, same frame again
                    state  <= S_IDLE;
                end
                default: state <= S_INIT;
            endcase
        end
    end

    //////////////////////////////
    // data path
    //////////////////////////////
    always_ff @(posedge clk) begin
        case (state)
            S_START: sof_addr <= rd_addr;
            S_PRIME: tx_data  <= rd_data_i;        // qword 0
            S_HOLD1: begin
                if (tx_ack_i) begin
                    tx_data <= rd_data_i;          // qword 1 straight through
                    qw_snt  <= QW_LEN_W'(2);
                end else begin
                    aux_data <= rd_data_i;         // park qword 1
                end
            end
            S_WAIT_ACK: begin
                if (tx_ack_i) begin
                    tx_data <= aux_data;
                    qw_snt  <= QW_LEN_W'(2);
                end
            end
            S_STREAM: begin
                tx_data <= rd_data_i;
                qw_snt  <= qw_snt + 1'b1;
            end
            default: ;
        endcase
    end

    // last qword of a frame may still be on the bus in the sync cycle
    a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
        (state == S_IDLE && !sync_o) |-> (tx_dv == '0 && !tx_start));

endmodule

`default_nettype wire

// File: eth_tx_top.sv
/*
 * eth tx top
 * host ingress, qword buffer, frame sync and sender
 */
`timescale 1ns/1ps
`default_nettype none

module eth_tx_top import eth_tx_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    // host
    input  wire logic      frm_start_i,
    input  wire frm_desc_t desc_i,
    input  wire logic      qw_wr_i,
    input  wire qw_t       qw_data_i,
    output logic           full_o,
    output logic           desc_full_o,
    // mac
    input  wire logic      tx_ack_i,
    output mac_tx_t        mac_o
);

    //////////////////////////////
    // interconnect
    //////////////////////////////
    logic          desc_push;
    frm_desc_t     push_desc;
    logic          desc_full;
    ptr_t          prod_ptr;
    ptr_t          committed_cons;
    logic          wr_en;
    logic [BW-1:0] wr_addr;
    qw_t           wr_data;
    logic [BW-1:0] rd_addr;
    qw_t           rd_data;
    logic          trig;
    ptr_t          diff;
    frm_desc_t     head_desc;
    logic          rsk;
    logic          rsk_tk;
    logic          sync;
    logic          eof;

    eth_tx_ingress u_ingress (
        .clk(clk), .rst(rst),
        .frm_start_i(frm_start_i), .desc_i(desc_i),
        .qw_wr_i(qw_wr_i), .qw_data_i(qw_data_i),
        .committed_cons_i(committed_cons), .desc_full_i(desc_full),
        .full_o(full_o), .desc_full_o(desc_full_o),
        .desc_push_o(desc_push), .desc_o(push_desc),
        .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data),
        .prod_ptr_o(prod_ptr)
    );

    eth_tx_ibuf u_ibuf (
        .clk(clk),
        .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
        .rd_addr_i(rd_addr), .rd_data_o(rd_data)
    );

    eth_tx_frm_sync u_frm_sync (
        .clk(clk), .rst(rst),
        .desc_push_i(desc_push), .desc_i(push_desc), .prod_ptr_i(prod_ptr),
        .rd_addr_i(rd_addr), .sync_i(sync), .rsk_tk_i(rsk_tk), .eof_i(eof),
        .desc_full_o(desc_full), .trig_o(trig), .diff_o(diff),
        .head_desc_o(head_desc), .rsk_o(rsk)
    );

    eth_tx_sender u_sender (
        .clk(clk), .rst(rst),
        .trig_i(trig), .diff_i(diff), .head_desc_i(head_desc), .rsk_i(rsk),
        .rsk_tk_o(rsk_tk), .sync_o(sync), .eof_o(eof),
        .rd_addr_o(rd_addr), .rd_data_i(rd_data),
        .tx_ack_i(tx_ack_i), .mac_o(mac_o),
        .committed_cons_o(committed_cons)
    );

endmodule

`default_nettype wire

// File: tb_eth_tx.sv
/*
 * eth tx testbench
 * host writer, mac model with random ack delay,
 * reference frame queue and in-order frame checks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_eth_tx import eth_tx_pkg::*; ();

    localparam int CLK_PERIOD  = 10;
    localparam int RST_CYCLES  = 10;
    localparam int N_FRAMES    = 40;
    localparam int WATCHDOG_NS = (RST_CYCLES + 200 * N_FRAMES) * CLK_PERIOD;
    localparam logic [15:0] LFSR_SEED = 16'd42345;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;  // x^16+x^14+x^13+x^11+1

    typedef enum logic [1:0] {M_IDLE, M_FIRST, M_STREAM} mon_state_t;

    logic      clk;
    logic      rst;
    logic      frm_start_i;
    frm_desc_t desc_i;
    logic      qw_wr_i;
    qw_t       qw_data_i;
    logic      full_o;
    logic      desc_full_o;
    logic      tx_ack_i;
    mac_tx_t   mac_o;

    // oldest undelivered frame sits at the front
    qw_t  ref_data [$];
    int   ref_len  [$];
    ben_t ref_ben  [$];

    logic [15:0] host_lfsr;     // frame stimulus
    logic [15:0] mac_lfsr;      // ack delays, own stream
    logic [63:0] mac_rnd;
    mon_state_t  mon_state;
    int          ack_wait;
    int          qw_idx;        // next qword expected in the stream
    ben_t        exp_dv;
    int          n_val_err;
    int          n_chk_err;
    int          n_frames;
    int          n_starts;
    int          n_underrun;
    int          total_qw;
    int          urun_before;

    eth_tx_top uut (
        .clk(clk), .rst(rst),
        .frm_start_i(frm_start_i), .desc_i(desc_i),
        .qw_wr_i(qw_wr_i), .qw_data_i(qw_data_i),
        .full_o(full_o), .desc_full_o(desc_full_o),
        .tx_ack_i(tx_ack_i), .mac_o(mac_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////
    // helpers
    //////////////////////////////
    task automatic next_cycle();
        @(posedge clk);
        #1;  // drive and sample just after the edge
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, inout logic [15:0] st, output logic [63:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            v  = {v[62:0], st[0]};
            st = lfsr_next(st);
        end
    endtask

    task automatic flag_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] got);
        $display("ERROR at %0t ns: %s expected %h got %h", $time, name, exp, got);
        n_val_err++;
    endtask

    task automatic note_failure(input string what);
        $display("FAILURE at %0t ns: %s", $time, what);
        n_chk_err++;
    endtask

    task automatic print_summary();
        $display("errors: %0d value, %0d check; frames %0d/%0d, starts %0d, underruns %0d",
                 n_val_err, n_chk_err, n_frames, N_FRAMES, n_starts, n_underrun);
    endtask

    // descriptor first, then the qwords; optional stall mid-frame
    task automatic send_frame(input int fix_len, input int stall_at, input int stall_cycles);
        frm_desc_t   desc;
        qw_t         fdata [40];
        logic [63:0] r;
        int          len;
        int          nb;
        int          i;
        logic        stalled;
        take_bits(6, host_lfsr, r);
        len = (fix_len > 0) ? fix_len : 8 + int'(r % 33);   // 8 .. 40
        take_bits(3, host_lfsr, r);
        nb           = int'(r) + 1;                          // 1 .. 8 bytes
        desc.qw_len  = QW_LEN_W'(len);
        desc.lst_ben = ben_t'((16'h1 << nb) - 16'h1);
        for (i = 0; i < len; i++) begin
            take_bits(64, host_lfsr, r);
            fdata[i] = r;
            ref_data.push_back(r);
        end
        ref_len.push_back(len);
        ref_ben.push_back(desc.lst_ben);
        total_qw += len;

        while (desc_full_o) next_cycle();
        frm_start_i = 1'b1;
        desc_i      = desc;
        next_cycle();
        frm_start_i = 1'b0;

        i       = 0;
        stalled = 1'b0;
        while (i < len) begin
            if (i == stall_at && stall_cycles > 0 && !stalled) begin
                qw_wr_i = 1'b0;
                stalled = 1'b1;
                repeat (stall_cycles) next_cycle();
            end
            if (!full_o) begin
                qw_wr_i   = 1'b1;
                qw_data_i = fdata[i];
                i++;
            end else begin
                qw_wr_i = 1'b0;   // back off, buffer full
            end
            next_cycle();
        end
        qw_wr_i = 1'b0;
    endtask

    task automatic wait_drained();
        while (ref_len.size() != 0) next_cycle();   // watchdog bounds this
    endtask

    //////////////////////////////
    // mac model and monitor
    //////////////////////////////
    initial begin
        tx_ack_i  = 1'b0;
        mon_state = M_IDLE;
        forever begin
            next_cycle();
            tx_ack_i = 1'b0;   // ack is a single-cycle level
            if (!rst) begin
                case (mon_state)
                    M_IDLE: begin
                        assert (mac_o.data_valid == 8'h00)
                            else flag_mismatch("mac_o.data_valid", 0, mac_o.data_valid);
                        assert (!mac_o.underrun)
                            else flag_mismatch("mac_o.underrun", 0, mac_o.underrun);
                        if (mac_o.start) begin
                            n_starts++;
                            assert (ref_len.size() > 0)
                                else note_failure("start pulse with no frame announced");
                            if (ref_len.size() > 0) begin
                                take_bits(3, mac_lfsr, mac_rnd);
                                ack_wait  = int'(mac_rnd % 6);   // 0 .. 5 cycles
                                mon_state = M_FIRST;
                            end
                        end
                    end
                    M_FIRST: begin
                        // qword 0 stays up until the ack is taken
                        assert (mac_o.data_valid == 8'hFF)
                            else flag_mismatch("mac_o.data_valid", 8'hFF, mac_o.data_valid);
                        assert (mac_o.data == ref_data[0])
                            else flag_mismatch("mac_o.data", ref_data[0], mac_o.data);
                        assert (!mac_o.start && !mac_o.underrun)
                            else note_failure("start or underrun while qword 0 waits for ack");
                        if (ack_wait == 0) begin
                            tx_ack_i  = 1'b1;
                            qw_idx    = 1;
                            mon_state = M_STREAM;
                        end else begin
                            ack_wait--;
                        end
                    end
                    M_STREAM: begin
                        if (mac_o.underrun) begin
                            // aborted attempt, same frame stays at the front
                            assert (mac_o.data_valid == 8'h00)
                                else flag_mismatch("mac_o.data_valid", 0, mac_o.data_valid);
                            n_underrun++;
                            mon_state = M_IDLE;
                        end else begin
                            exp_dv = (qw_idx == ref_len[0] - 1) ? ref_ben[0] : 8'hFF;
                            assert (mac_o.data_valid == exp_dv)
                                else flag_mismatch("mac_o.data_valid", exp_dv, mac_o.data_valid);
                            assert (mac_o.data == ref_data[qw_idx])
                                else flag_mismatch("mac_o.data", ref_data[qw_idx], mac_o.data);
                            assert (!mac_o.start)
                                else note_failure("start pulse in the middle of a frame");
                            qw_idx++;
                            if (qw_idx == ref_len[0]) begin
                                repeat (ref_len[0]) void'(ref_data.pop_front());
                                void'(ref_len.pop_front());
                                void'(ref_ben.pop_front());
                                n_frames++;
                                mon_state = M_IDLE;
                            end
                        end
                    end
                    default: mon_state = M_IDLE;
                endcase
            end
        end
    end

    //////////////////////////////
    // watchdog
    //////////////////////////////
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: the run did not finish within %0d ns", WATCHDOG_NS);
        print_summary();
        $display("Something failed");
        $finish;
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////
    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        frm_start_i = 1'b0;
        desc_i      = '0;
        qw_wr_i     = 1'b0;
        qw_data_i   = '0;
        host_lfsr   = LFSR_SEED;
        mac_lfsr    = LFSR_SEED;
        n_val_err   = 0;
        n_chk_err   = 0;
        n_frames    = 0;
        n_starts    = 0;
        n_underrun  = 0;
        total_qw    = 0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (8) next_cycle();   // line must stay quiet here

        repeat (5) begin           // single frames, idle line between them
            send_frame(0, 0, 0);
            wait_drained();
        end
        repeat (15) send_frame(0, 0, 0);   // back to back
        wait_drained();
        // host never stalled so far
        assert (n_underrun == 0)
            else flag_mismatch("n_underrun", 0, n_underrun);

        // host stalls long enough for the sender to catch up
        urun_before = n_underrun;
        send_frame(32, 10, 100);
        wait_drained();
        assert (n_underrun > urun_before)
            else note_failure("no underrun seen on the stalled frame");
        urun_before = n_underrun;

        repeat (19) send_frame(0, 0, 0);
        wait_drained();
        repeat (4) next_cycle();

        assert (n_underrun == urun_before)
            else flag_mismatch("n_underrun", urun_before, n_underrun);
        // each start ends in a delivered frame or an underrun
        assert (n_starts == n_frames + n_underrun)
            else flag_mismatch("n_starts", n_frames + n_underrun, n_starts);
        assert (total_qw > BUF_QW)
            else note_failure("stimulus did not wrap the buffer");
        assert (n_frames == N_FRAMES)
            else flag_mismatch("n_frames", N_FRAMES, n_frames);
        assert (full_o == 1'b0)
            else flag_mismatch("full_o", 0, full_o);
        assert (desc_full_o == 1'b0)
            else flag_mismatch("desc_full_o", 0, desc_full_o);

        print_summary();
        if (n_val_err == 0 && n_chk_err == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: eth_tx.f
eth_tx_pkg.sv
eth_tx_ibuf.sv
eth_tx_ingress.sv
eth_tx_frm_sync.sv
eth_tx_sender.sv
eth_tx_top.sv
tb_eth_tx.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the eth tx testbench with verilator
set -eo pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    -Wno-fatal \
    --top-module tb_eth_tx \
    -f eth_tx.f \
    -o sim_eth_tx

./obj_dir/sim_eth_tx | tee "$LOG"

if grep -q "Something failed" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi
echo "simulation passed"
